/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // ########################################
    // Instruction classes and ALU operations
    // ########################################

    typedef enum logic [4:0] {
        OPCODE_NOP    = 5'h00,
        OPCODE_LOAD   = 5'h01,
        OPCODE_STORE  = 5'h02,
        OPCODE_ALUM   = 5'h03,
        OPCODE_ALUMI  = 5'h04,
        OPCODE_ALU    = 5'h05,
        OPCODE_BRANCH = 5'h06,
        OPCODE_JUMP   = 5'h07
    } t_opcode;

    // Top bit selects the extended set
    typedef enum logic [4:0] {
        OP_ADD  = 5'h00,
        OP_SUB  = 5'h01,
        OP_AND  = 5'h02,
        OP_OR   = 5'h03,
        OP_XOR  = 5'h04,
        OP_COPY = 5'h05,
        OP_SHL  = 5'h10,
        OP_SHR  = 5'h11,
        OP_SAR  = 5'h12,
        OP_CMP  = 5'h13
    } t_alu_op;

    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd0,
        WIDTH_HALF = 2'd1,
        WIDTH_WORD = 2'd2
    } t_cycle_width;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int REG_COUNT = 16;

    // Branch conditions, carried in the data register field
    localparam logic [3:0] COND_ALWAYS = 4'd0;
    localparam logic [3:0] COND_EQ     = 4'd1;
    localparam logic [3:0] COND_NE     = 4'd2;
    localparam logic [3:0] COND_LT     = 4'd3;
    localparam logic [3:0] COND_GE     = 4'd4;
    localparam logic [3:0] COND_CS     = 4'd5;
    localparam logic [3:0] COND_CC     = 4'd6;

    // ########################################
    // Stage registers and bus
    // ########################################

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } t_flags;

    typedef struct packed {
        logic [31:0]  instruction;
        logic [31:0]  address;
        logic         memory_access_cycle;
        logic         memory_read;
        logic         memory_write;
        t_cycle_width width;
        logic [15:0]  alu_immediate;
        logic [3:0]   reg_address_index;
        logic [3:0]   reg_data_index;
        logic [3:0]   reg_operand_index;
        t_alu_op      alu_op;
        logic         alu_immediate_cycle;
        logic         branch_cycle;
        logic         jump_cycle;
        logic         status_register_write;
    } t_decoded;

    typedef struct packed {
        logic [31:0] result;       // Effective address or value
        logic [31:0] store_data;
        t_flags      flags;
        t_decoded    ctrl;
    } t_executed;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } t_wb_req;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } t_wb_rsp;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             retire,
    input  logic [31:0]      next_pc,
    output cpu_pkg::t_wb_req fetch_req,
    input  cpu_pkg::t_wb_rsp fetch_rsp,
    output logic [31:0]      fetched_instruction,
    output logic [31:0]      fetched_address,
    output logic             fetch_done
);
    import cpu_pkg::*;

    logic [31:0] pc;
    logic        active;    // Bus cycle in progress
    logic        start;     // First fetch after reset
    logic        in_flight; // Word delivered but not yet retired

    assign fetch_req = '{cyc: active, stb: active, we: 1'b0,
                         adr: pc, dat: 32'h0, sel: 4'hf};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
            active <= 1'b0;
            start <= 1'b1;
            in_flight <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            start <= 1'b0;
            fetch_done <= 1'b0;
            if (start)
                active <= 1'b1;
            if (active && fetch_rsp.ack) begin
                active <= 1'b0;
                fetch_done <= 1'b1;
                in_flight <= 1'b1;
            end
            // Next fetch begins as soon as the instruction retires
            if (retire) begin
                pc <= next_pc;
                active <= 1'b1;
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (active && fetch_rsp.ack) begin
            fetched_instruction <= fetch_rsp.dat;
            fetched_address <= pc;
        end
    end

    // No fetch completes while an instruction is still in flight
    a_no_fetch_in_flight: assert property (@(posedge clock) disable iff (reset)
        fetch_rsp.ack |-> !in_flight);

    // Every retire from the core belongs to a fetched instruction
    a_retire_fetched: assert property (@(posedge clock) disable iff (reset)
        retire |-> in_flight);

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic              clock,
    input  logic              reset,
    input  logic              fetch_done,
    input  logic [31:0]       inbound_instruction,
    input  logic [31:0]       inbound_address,
    output cpu_pkg::t_decoded decoded,
    output logic              decoded_valid
);
    import cpu_pkg::*;

    t_opcode opcode;

    assign opcode = t_opcode'(inbound_instruction[31:27]);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            decoded <= '0;
            decoded.instruction <= {OPCODE_NOP, 27'h0};
            decoded_valid <= 1'b0;
        end else begin
            decoded_valid <= fetch_done;
            if (fetch_done) begin
                decoded.memory_access_cycle <= 1'b0;
                decoded.memory_read <= 1'b0;
                decoded.memory_write <= 1'b0;
                decoded.alu_immediate_cycle <= 1'b0;
                decoded.branch_cycle <= 1'b0;
                decoded.jump_cycle <= 1'b0;
                decoded.status_register_write <= 1'b0;
                decoded.alu_op <= OP_ADD;
                decoded.alu_immediate <= 16'h0;
                decoded.instruction <= inbound_instruction;

                case (opcode)
                    OPCODE_LOAD, OPCODE_STORE: begin
                        decoded.memory_access_cycle <= 1'b1;
                        decoded.memory_read <= (opcode == OPCODE_LOAD);
                        decoded.memory_write <= (opcode == OPCODE_STORE);
                        decoded.alu_immediate <= inbound_instruction[15:0];
                        decoded.alu_immediate_cycle <= 1'b1;
                    end
                    OPCODE_ALUM: begin
                        decoded.alu_op <= t_alu_op'({1'b0, inbound_instruction[15:12]});
                        decoded.status_register_write <= 1'b1;
                    end
                    OPCODE_ALUMI: begin
                        decoded.alu_op <= t_alu_op'({1'b0, inbound_instruction[15:12]});
                        decoded.alu_immediate <= {inbound_instruction[26],
                            inbound_instruction[26:24], inbound_instruction[11:0]};
                        decoded.alu_immediate_cycle <= 1'b1;
                        decoded.status_register_write <= 1'b1;
                    end
                    OPCODE_ALU: begin
                        decoded.alu_op <= t_alu_op'({1'b1, inbound_instruction[15:12]});
                        decoded.status_register_write <= 1'b1;
                    end
                    OPCODE_BRANCH: begin
                        // Word offset, scaled in execute
                        decoded.alu_immediate <= {inbound_instruction[19:16],
                            inbound_instruction[11:0]};
                        decoded.alu_immediate_cycle <= 1'b1;
                        decoded.branch_cycle <= 1'b1;
                    end
                    OPCODE_JUMP: begin
                        decoded.alu_op <= OP_COPY;
                        decoded.jump_cycle <= 1'b1;
                    end
                    default: begin
                        decoded.instruction <= {OPCODE_NOP, 27'h0}; // Unknown runs as NOP
                    end
                endcase

                decoded.width <= t_cycle_width'(inbound_instruction[26:25]);
                decoded.reg_address_index <= inbound_instruction[19:16];
                decoded.reg_data_index <= inbound_instruction[23:20];
                decoded.reg_operand_index <= inbound_instruction[11:8];
                decoded.address <= inbound_address;
            end
        end
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clock,
    input  logic        reset,
    input  logic [3:0]  read_index_a,
    input  logic [3:0]  read_index_b,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    input  logic        write_enable,
    input  logic [3:0]  write_index,
    input  logic [31:0] write_data
);
    import cpu_pkg::*;

    logic [31:0] registers [REG_COUNT];

    assign read_data_a = registers[read_index_a];
    assign read_data_b = registers[read_index_b];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++)
                registers[i] <= 32'h0;
        end else if (write_enable) begin
            registers[write_index] <= write_data;
        end
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::t_alu_op alu_op,
    input  logic [31:0]      operand_a,
    input  logic [31:0]      operand_b,
    output logic [31:0]      result,
    output cpu_pkg::t_flags  flags
);
    import cpu_pkg::*;

    logic [32:0] sum;
    logic [32:0] difference;
    logic [31:0] flag_source;

    assign sum = {1'b0, operand_a} + {1'b0, operand_b};
    assign difference = {1'b0, operand_a} - {1'b0, operand_b};

    always_comb begin
        case (alu_op)
            OP_ADD:  result = sum[31:0];
            OP_SUB:  result = difference[31:0];
            OP_AND:  result = operand_a & operand_b;
            OP_OR:   result = operand_a | operand_b;
            OP_XOR:  result = operand_a ^ operand_b;
            OP_SHL:  result = operand_a << operand_b[4:0];
            OP_SHR:  result = operand_a >> operand_b[4:0];
            OP_SAR:  result = $signed(operand_a) >>> operand_b[4:0];
            default: result = operand_a; // Copy and compare pass operand_a
        endcase
    end

    // Compare sets the flags of a subtraction without keeping its value
    assign flag_source = (alu_op == OP_CMP) ? difference[31:0] : result;

    always_comb begin
        flags.zero = (flag_source == 32'h0);
        flags.negative = flag_source[31];
        flags.carry = 1'b0;
        flags.overflow = 1'b0;
        if (alu_op == OP_ADD) begin
            flags.carry = sum[32];
            flags.overflow = (operand_a[31] == operand_b[31]) && (sum[31] != operand_a[31]);
        end else if (alu_op == OP_SUB || alu_op == OP_CMP) begin
            flags.carry = difference[32]; // Borrow
            flags.overflow = (operand_a[31] != operand_b[31])
                && (difference[31] != operand_a[31]);
        end
    end

endmodule

/* hdl/memory_unit.sv */
`timescale 1ns/1ps

module memory_unit (
    input  logic             clock,
    input  logic             reset,
    input  cpu_pkg::t_wb_req fetch_req,
    output cpu_pkg::t_wb_rsp fetch_rsp,
    input  cpu_pkg::t_wb_req data_req,
    output cpu_pkg::t_wb_rsp data_rsp,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [31:0]      wb_adr,
    output logic [31:0]      wb_dat_w,
    output logic [3:0]       wb_sel,
    input  logic [31:0]      wb_dat_r,
    input  logic             wb_ack
);
    import cpu_pkg::*;

    logic        busy;
    logic        data_owner_q;
    logic        data_owner;
    logic        is_word;
    logic        is_half;
    logic [31:0] lane_shifted;
    logic [31:0] store_lanes;

    // Grant is taken when the bus is idle and held until ack
    assign data_owner = busy ? data_owner_q : data_req.cyc;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            data_owner_q <= 1'b0;
        end else if (!busy && (fetch_req.cyc || data_req.cyc)) begin
            busy <= 1'b1;
            data_owner_q <= data_req.cyc;
        end else if (busy && wb_ack) begin
            busy <= 1'b0;
        end
    end

    // Width travels as the unshifted select mask
    assign is_word = (data_req.sel == 4'b1111);
    assign is_half = (data_req.sel == 4'b0011);

    assign store_lanes = is_word ? data_req.dat :
                         is_half ? {2{data_req.dat[15:0]}} : {4{data_req.dat[7:0]}};
    assign lane_shifted = wb_dat_r >> {data_req.adr[1:0], 3'b000};

    assign wb_cyc = data_owner ? data_req.cyc : fetch_req.cyc;
    assign wb_stb = data_owner ? data_req.stb : fetch_req.stb;
    assign wb_we = data_owner & data_req.we;
    assign wb_adr = data_owner ? {data_req.adr[31:2], 2'b00} : fetch_req.adr;
    assign wb_dat_w = data_owner ? store_lanes : 32'h0;
    assign wb_sel = data_owner ? data_req.sel << data_req.adr[1:0] : fetch_req.sel;

    assign fetch_rsp.ack = wb_ack & ~data_owner;
    assign fetch_rsp.dat = wb_dat_r;
    assign data_rsp.ack = wb_ack & data_owner;
    assign data_rsp.dat = is_word ? lane_shifted :
                          is_half ? {16'h0, lane_shifted[15:0]} : {24'h0, lane_shifted[7:0]};

    a_one_owner: assert property (@(posedge clock) disable iff (reset)
        !(fetch_req.cyc && data_req.cyc));

    a_half_aligned: assert property (@(posedge clock) disable iff (reset)
        data_req.stb && is_half |-> !data_req.adr[0]);

    a_word_aligned: assert property (@(posedge clock) disable iff (reset)
        data_req.stb && is_word |-> data_req.adr[1:0] == 2'b00);

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic        clock,
    input  logic        reset,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_r,
    input  logic        wb_ack
);
    import cpu_pkg::*;

    t_wb_req     fetch_req, data_req;
    t_wb_rsp     fetch_rsp, data_rsp;
    logic [31:0] fetched_instruction, fetched_address;
    logic        fetch_done;
    t_decoded    decoded;
    logic        decoded_valid;
    logic [3:0]  read_index_b;
    logic [31:0] read_data_a, read_data_b;
    logic [31:0] immediate, operand_a, operand_b, alu_result;
    t_flags      alu_flags, status;
    t_executed   executed;
    logic        mem_active, wb_valid, retire, condition_met, reg_write;
    logic [31:0] load_data, pc_plus4, next_pc;
    logic [3:0]  sel_mask;
    t_opcode     wb_opcode;

    fetch_unit fetch0 (.clock, .reset, .retire, .next_pc, .fetch_req, .fetch_rsp,
        .fetched_instruction, .fetched_address, .fetch_done);

    decode_stage decode0 (.clock, .reset, .fetch_done,
        .inbound_instruction(fetched_instruction), .inbound_address(fetched_address),
        .decoded, .decoded_valid);

    // ########################################
    // Execute
    // ########################################

    assign read_index_b = decoded.memory_write ? decoded.reg_data_index
                                               : decoded.reg_operand_index;

    register_file regs0 (.clock, .reset, .read_index_a(decoded.reg_address_index),
        .read_index_b, .read_data_a, .read_data_b, .write_enable(reg_write),
        .write_index(executed.ctrl.reg_data_index), .write_data(
            executed.ctrl.memory_read ? load_data : executed.result));

    assign immediate = {{16{decoded.alu_immediate[15]}}, decoded.alu_immediate};
    assign operand_a = decoded.branch_cycle ? decoded.address + 32'd4 : read_data_a;
    assign operand_b = !decoded.alu_immediate_cycle ? read_data_b :
                       decoded.branch_cycle ? immediate << 2 : immediate;

    alu alu0 (.alu_op(decoded.alu_op), .operand_a, .operand_b,
        .result(alu_result), .flags(alu_flags));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            executed <= '0;
            mem_active <= 1'b0;
            wb_valid <= 1'b0;
            status <= '0;
        end else begin
            wb_valid <= 1'b0;
            if (decoded_valid) begin
                executed <= '{result: alu_result, store_data: read_data_b,
                              flags: alu_flags, ctrl: decoded};
                mem_active <= decoded.memory_access_cycle;
                wb_valid <= !decoded.memory_access_cycle; // Skip the memory stage
            end
            if (mem_active && data_rsp.ack) begin
                mem_active <= 1'b0;
                wb_valid <= 1'b1;
            end
            if (retire && executed.ctrl.status_register_write)
                status <= executed.flags;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_active && data_rsp.ack)
            load_data <= data_rsp.dat;
    end

    // ########################################
    // Memory and writeback
    // ########################################

    always_comb begin
        case (executed.ctrl.width)
            WIDTH_BYTE: sel_mask = 4'b0001;
            WIDTH_HALF: sel_mask = 4'b0011;
            default:    sel_mask = 4'b1111;
        endcase
    end

    assign data_req = '{cyc: mem_active, stb: mem_active, we: executed.ctrl.memory_write,
                        adr: executed.result, dat: executed.store_data, sel: sel_mask};

    memory_unit mem0 (.clock, .reset, .fetch_req, .fetch_rsp, .data_req, .data_rsp,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack);

    assign retire = wb_valid;
    assign wb_opcode = t_opcode'(executed.ctrl.instruction[31:27]);
    assign reg_write = retire && (wb_opcode == OPCODE_LOAD || wb_opcode == OPCODE_ALUM
                               || wb_opcode == OPCODE_ALUMI || wb_opcode == OPCODE_ALU);

    always_comb begin
        case (executed.ctrl.reg_data_index)
            COND_ALWAYS: condition_met = 1'b1;
            COND_EQ:     condition_met = status.zero;
            COND_NE:     condition_met = !status.zero;
            COND_LT:     condition_met = status.negative ^ status.overflow;
            COND_GE:     condition_met = !(status.negative ^ status.overflow);
            COND_CS:     condition_met = status.carry;
            COND_CC:     condition_met = !status.carry;
            default:     condition_met = 1'b0;
        endcase
    end

    // Branch result already holds PC+4 plus the scaled offset
    assign pc_plus4 = executed.ctrl.address + 32'd4;
    assign next_pc = executed.ctrl.jump_cycle ? executed.result :
                     (executed.ctrl.branch_cycle && condition_met) ? executed.result
                                                                   : pc_plus4;

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input  logic        clock,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    input  logic        wb_ack,
    input  logic [31:0] image [256],
    input  logic [31:0] halt_address,
    output logic        done,
    output int          error_count
);
    import cpu_pkg::*;

    string       names [6] = '{"fetch order", "alu results", "flags", "loads", "stores", "reset"};
    int          checks [6] = '{default: 0};
    int          fails [6] = '{default: 0};
    int          errors = 0;
    logic        finished = 1'b0;
    logic [31:0] mem [256];
    logic [31:0] regs [16];
    int          written_by [16]; // Category of the last write to each register
    logic [31:0] pc, next_pc, ea;
    logic        flag_z, flag_n, flag_c, flag_v;
    logic        data_pending, is_store, after_branch, first_fetch;
    logic [1:0]  width;
    logic [3:0]  data_reg;

    assign done = finished;
    assign error_count = errors;

    task automatic check(input int cat, input logic ok, input string msg);
        checks[cat]++;
        if (!ok) begin
            fails[cat]++;
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    task automatic model_alu(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                             input logic [3:0] rd);
        logic [32:0] wide;
        logic [31:0] r;
        flag_c = 1'b0;
        flag_v = 1'b0;
        case (op)
            OP_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0];
                flag_c = wide[32];
                flag_v = (a[31] == b[31]) && (r[31] != a[31]);
            end
            OP_SUB, OP_CMP: begin
                wide = {1'b0, a} - {1'b0, b};
                r = wide[31:0];
                flag_c = wide[32]; // Borrow
                flag_v = (a[31] != b[31]) && (r[31] != a[31]);
            end
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SHL:  r = a << b[4:0];
            OP_SHR:  r = a >> b[4:0];
            OP_SAR:  r = $signed(a) >>> b[4:0];
            default: r = a;
        endcase
        flag_z = (r == 32'h0);
        flag_n = r[31];
        regs[rd] = (op == OP_CMP) ? a : r;
        written_by[rd] = 1;
    endtask

    function automatic logic cond_met(input logic [3:0] cc);
        case (cc)
            COND_ALWAYS: return 1'b1;
            COND_EQ:     return flag_z;
            COND_NE:     return !flag_z;
            COND_LT:     return flag_n ^ flag_v;
            COND_GE:     return !(flag_n ^ flag_v);
            COND_CS:     return flag_c;
            COND_CC:     return !flag_c;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic execute(input logic [31:0] ins);
        logic [31:0] imm;
        imm = {{17{ins[26]}}, ins[26:24], ins[11:0]};
        next_pc = pc + 32'd4;
        case (t_opcode'(ins[31:27]))
            OPCODE_LOAD, OPCODE_STORE: begin
                ea = regs[ins[19:16]] + {{16{ins[15]}}, ins[15:0]};
                data_pending = 1'b1;
                is_store = (ins[31:27] == OPCODE_STORE);
                width = ins[26:25];
                data_reg = ins[23:20];
            end
            OPCODE_ALUM:  model_alu({1'b0, ins[15:12]}, regs[ins[19:16]], regs[ins[11:8]],
                                    ins[23:20]);
            OPCODE_ALUMI: model_alu({1'b0, ins[15:12]}, regs[ins[19:16]], imm, ins[23:20]);
            OPCODE_ALU:   model_alu({1'b1, ins[15:12]}, regs[ins[19:16]], regs[ins[11:8]],
                                    ins[23:20]);
            OPCODE_BRANCH: begin
                if (cond_met(ins[23:20]))
                    next_pc = pc + 32'd4 + {{14{ins[19]}}, ins[19:16], ins[11:0], 2'b00};
                after_branch = (ins[23:20] != COND_ALWAYS);
            end
            OPCODE_JUMP: next_pc = regs[ins[19:16]];
            default: ;
        endcase
        if (!data_pending)
            pc = next_pc;
    endtask

    task automatic data_access();
        logic [3:0]  sel;
        logic [31:0] lanes;
        logic [31:0] word;
        case (width)
            2'd0: begin
                sel = 4'b0001 << ea[1:0];
                lanes = {4{regs[data_reg][7:0]}};
            end
            2'd1: begin
                sel = 4'b0011 << ea[1:0];
                lanes = {2{regs[data_reg][15:0]}};
            end
            default: begin
                sel = 4'b1111;
                lanes = regs[data_reg];
            end
        endcase
        check(is_store ? 4 : 3,
            wb_we == is_store && wb_adr == {ea[31:2], 2'b00} && wb_sel == sel,
            $sformatf("access we %b adr %h sel %b, expected %b %h %b",
                wb_we, wb_adr, wb_sel, is_store, {ea[31:2], 2'b00}, sel));
        if (is_store) begin
            check(written_by[data_reg] == 0 ? 4 : written_by[data_reg], wb_dat_w == lanes,
                $sformatf("store data %h, expected %h", wb_dat_w, lanes));
            for (int b = 0; b < 4; b++)
                if (sel[b])
                    mem[ea[9:2]][8*b +: 8] = lanes[8*b +: 8];
        end else begin
            word = mem[ea[9:2]] >> {ea[1:0], 3'b000};
            if (width == 2'd0)
                word = word & 32'h0000_00ff;
            else if (width == 2'd1)
                word = word & 32'h0000_ffff;
            regs[data_reg] = word;
            written_by[data_reg] = 3;
        end
        data_pending = 1'b0;
        pc = next_pc;
    endtask

    task automatic report();
        finished = 1'b1;
        for (int i = 0; i < 6; i++)
            $display("%s: %0d checks, %0d errors", names[i], checks[i], fails[i]);
        $display("Total errors: %0d", errors);
    endtask

    // ########################################
    // Bus monitor
    // ########################################

    always @(posedge clock) begin
        if (reset) begin
            check(5, !wb_cyc && !wb_stb, "bus cycle active during reset");
            mem = image;
            for (int i = 0; i < 16; i++) begin
                regs[i] = 32'h0;
                written_by[i] = 0;
            end
            pc = RESET_PC;
            {flag_z, flag_n, flag_c, flag_v} = 4'h0;
            data_pending = 1'b0;
            first_fetch = 1'b1;
            after_branch = 1'b0;
        end else if (!finished && wb_cyc && wb_stb && wb_ack) begin
            if (data_pending) begin
                data_access();
            end else begin
                check(first_fetch ? 5 : after_branch ? 2 : 0, wb_adr == pc && !wb_we,
                    $sformatf("fetch from %h, expected %h", wb_adr, pc));
                first_fetch = 1'b0;
                after_branch = 1'b0;
                if (pc == halt_address)
                    report();
                else
                    execute(mem[pc[9:2]]);
            end
        end
    end

endmodule

/* tb/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int HALT_WORD = 216;  // Prologue of 16 plus 200 random instructions
    localparam int DATA_WORD = 224;  // Data region at 0x380
    localparam int WATCHDOG_CYCLES = HALT_WORD * 10 * 4 + 2000;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic        wb_cyc, wb_stb, wb_we;
    logic [31:0] wb_adr, wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r = 32'h0;
    logic        wb_ack = 1'b0;
    integer      seed = 32'h3b70387a;
    logic [31:0] image [256];
    logic [31:0] mem [256];
    bit          is_target [256];
    logic        pending = 1'b0;
    int          wait_left = 0;
    logic        done;
    int          error_count;

    always #50 clock = ~clock;

    cpu_core dut0 (.clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
        .wb_dat_r, .wb_ack);

    cpu_checker checker0 (.clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_sel, .wb_ack, .image, .halt_address(32'(HALT_WORD * 4)), .done, .error_count);

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] alumi(input int fn, input int rd, input int ra,
                                          input logic [15:0] imm);
        return {OPCODE_ALUMI, imm[14:12], 4'(rd), 4'(ra), 4'(fn), imm[11:0]};
    endfunction

    function automatic logic [31:0] mem_op(input t_opcode op, input int rd);
        logic [1:0]  w;
        logic [15:0] off;
        w = 2'(rnd(3));
        off = 16'(rnd(128)) & (w == 2'd0 ? 16'hffff : w == 2'd1 ? 16'hfffe : 16'hfffc);
        return {op, w, 1'b0, 4'(rd), 4'd15, off}; // r15 holds the data base
    endfunction

    // ########################################
    // Program generator
    // ########################################

    initial begin
        int          i;
        int          t;
        logic [15:0] imm;
        for (int k = 0; k < 256; k++)
            image[k] = (k >= DATA_WORD) ? $random(seed) : 32'h0;
        for (int r = 0; r < 15; r++) begin
            imm = 16'($random(seed));
            imm[15] = imm[14];
            image[r] = alumi(0, r, r, imm);
        end
        image[15] = alumi(0, 15, 15, 16'h0380);
        i = 16;
        while (i < HALT_WORD) begin
            case (rnd(8))
                0: image[i] = {OPCODE_ALUM, 3'b0, 4'(rnd(14)), 4'(rnd(16)), 4'(rnd(6)),
                               4'(rnd(16)), 8'h0};
                1: begin
                    imm = 16'($random(seed));
                    imm[15] = imm[14];
                    image[i] = alumi(rnd(6), rnd(14), rnd(16), imm);
                end
                2: image[i] = {OPCODE_ALU, 3'b0, 4'(rnd(14)), 4'(rnd(16)), 4'(rnd(4)),
                               4'(rnd(16)), 8'h0};
                3: image[i] = mem_op(OPCODE_LOAD, rnd(14));
                4, 7: image[i] = mem_op(OPCODE_STORE, rnd(16));
                5: begin
                    t = i + 1 + rnd(4);
                    t = (t > HALT_WORD) ? HALT_WORD : t;
                    is_target[t] = 1'b1;
                    image[i] = {OPCODE_BRANCH, 3'b0, 4'(rnd(8)), 4'h0, 4'h0, 12'(t - i - 1)};
                end
                default: begin
                    // Target register and jump stay together so no branch lands between them
                    if (i + 1 < HALT_WORD && !is_target[i + 1]) begin
                        t = i + 2 + rnd(4);
                        t = (t > HALT_WORD) ? HALT_WORD : t;
                        is_target[t] = 1'b1;
                        image[i] = alumi(4, 14, 15, 16'(t * 4) ^ 16'h0380);
                        image[i + 1] = {OPCODE_JUMP, 7'h0, 4'd14, 16'h0};
                        i++;
                    end else begin
                        image[i] = 32'h0;
                    end
                end
            endcase
            i++;
        end
        image[HALT_WORD] = {OPCODE_BRANCH, 3'b0, COND_ALWAYS, 4'hf, 4'h0, 12'hfff};
    end

    initial begin
        repeat (10) @(posedge clock);
        reset <= 1'b0;
    end

    // Wishbone memory with random wait states
    always @(posedge clock) begin
        if (reset) begin
            mem <= image;
            wb_ack <= 1'b0;
            pending <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!pending) begin
                    pending <= 1'b1;
                    wait_left <= rnd(4);
                end else if (wait_left == 0) begin
                    pending <= 1'b0;
                    wb_ack <= 1'b1;
                    wb_dat_r <= mem[wb_adr[9:2]];
                    if (wb_we)
                        for (int b = 0; b < 4; b++)
                            if (wb_sel[b])
                                mem[wb_adr[9:2]][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

    initial begin
        wait (done);
        @(posedge clock);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the program never reached its final instruction");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* cpu_core.f */
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/alu.sv
hdl/memory_unit.sv
hdl/cpu_core.sv
tb/cpu_checker.sv
tb/tb_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f cpu_core.f --top-module tb_cpu_core -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
